/* design/dma_pkg.sv */
// Shared constants, types and priority helpers for the DMA arbiter, imported by every RTL file
package dma_pkg;

    localparam int num_channels = 4;

    typedef logic [1:0]              channel_t;
    typedef logic [num_channels-1:0] channel_vec_t;

    // Register map of the CPU write port
    localparam logic [3:0] addr_count_0      = 4'd0;
    localparam logic [3:0] addr_count_1      = 4'd1;
    localparam logic [3:0] addr_count_2      = 4'd2;
    localparam logic [3:0] addr_count_3      = 4'd3;
    localparam logic [3:0] addr_command      = 4'd8;
    localparam logic [3:0] addr_request      = 4'd9;
    localparam logic [3:0] addr_single_mask  = 4'd10;
    localparam logic [3:0] addr_mode         = 4'd11;
    localparam logic [3:0] addr_master_clear = 4'd13;
    localparam logic [3:0] addr_clear_mask   = 4'd14;
    localparam logic [3:0] addr_all_mask     = 4'd15;

    localparam int cmd_disable_bit    = 2;
    localparam int cmd_rotate_bit     = 4;
    localparam int cmd_active_low_bit = 6;

    // Set or clear flag in single mask and request writes, channel in bits 1..0
    localparam int set_bit = 2;

    localparam int mode_edge_bit = 7;

    // Moves bit "amount" down to bit 0
    function automatic channel_vec_t rotate_right(channel_vec_t value, channel_t amount);
        logic [2*num_channels-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[num_channels-1:0];
    endfunction

    function automatic channel_vec_t rotate_left(channel_vec_t value, channel_t amount);
        logic [2*num_channels-1:0] doubled;
        doubled = {value, value} << amount;
        return doubled[2*num_channels-1:num_channels];
    endfunction

    // Lowest set bit wins
    function automatic channel_vec_t resolve_priority(channel_vec_t value);
        return value & (channel_vec_t'(~value) + channel_vec_t'(1));
    endfunction

endpackage

/* design/dma_ctrl_if.sv */
// Internal register bus from the write decoder to the priority encoder and service sequencer
interface dma_ctrl_if;
    import dma_pkg::*;

    logic [7:0] internal_data;
    logic       write_command;
    logic       write_request;
    logic       write_single_mask;
    logic       write_all_mask;
    logic       write_mode;
    logic       write_count;
    channel_t   count_select;
    logic       master_clear;
    logic       clear_mask;

    modport decoder (
        output internal_data, write_command, write_request, write_single_mask,
               write_all_mask, write_mode, write_count, count_select,
               master_clear, clear_mask
    );

    modport encoder (
        input internal_data, write_command, write_request, write_single_mask,
              write_all_mask, master_clear, clear_mask
    );

    // Sequencer only sees mode, count and master clear
    modport sequencer (
        input internal_data, write_mode, write_count, count_select, master_clear
    );

endinterface

/* design/dma_register_decoder.sv */
// Registers CPU writes and decodes them into single-cycle strobes on the internal register bus
module dma_register_decoder (
    input  logic           clock,
    input  logic           reset,
    input  logic           cpu_write_i,
    input  logic [3:0]     cpu_address_i,
    input  logic [7:0]     cpu_data_i,
    dma_ctrl_if.decoder    ctrl_o
);
    import dma_pkg::*;

    logic       write_q;
    logic [3:0] address_q;
    logic [7:0] data_q;

    logic       command_next;
    logic       request_next;
    logic       single_mask_next;
    logic       all_mask_next;
    logic       mode_next;
    logic       count_next;
    logic       master_clear_next;
    logic       clear_mask_next;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_q <= 1'b0;
        end else begin
            write_q <= cpu_write_i;
        end
    end

    always_ff @(posedge clock) begin
        address_q <= cpu_address_i;
        data_q    <= cpu_data_i;
    end

    always_comb begin
        command_next      = 1'b0;
        request_next      = 1'b0;
        single_mask_next  = 1'b0;
        all_mask_next     = 1'b0;
        mode_next         = 1'b0;
        count_next        = 1'b0;
        master_clear_next = 1'b0;
        clear_mask_next   = 1'b0;
        if (write_q) begin
            case (address_q)
                addr_count_0, addr_count_1,
                addr_count_2, addr_count_3: count_next        = 1'b1;
                addr_command:               command_next      = 1'b1;
                addr_request:               request_next      = 1'b1;
                addr_single_mask:           single_mask_next  = 1'b1;
                addr_mode:                  mode_next         = 1'b1;
                addr_master_clear:          master_clear_next = 1'b1;
                addr_clear_mask:            clear_mask_next   = 1'b1;
                addr_all_mask:              all_mask_next     = 1'b1;
                default:                    count_next        = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ctrl_o.write_command     <= 1'b0;
            ctrl_o.write_request     <= 1'b0;
            ctrl_o.write_single_mask <= 1'b0;
            ctrl_o.write_all_mask    <= 1'b0;
            ctrl_o.write_mode        <= 1'b0;
            ctrl_o.write_count       <= 1'b0;
            ctrl_o.master_clear      <= 1'b0;
            ctrl_o.clear_mask        <= 1'b0;
        end else begin
            ctrl_o.write_command     <= command_next;
            ctrl_o.write_request     <= request_next;
            ctrl_o.write_single_mask <= single_mask_next;
            ctrl_o.write_all_mask    <= all_mask_next;
            ctrl_o.write_mode        <= mode_next;
            ctrl_o.write_count       <= count_next;
            ctrl_o.master_clear      <= master_clear_next;
            ctrl_o.clear_mask        <= clear_mask_next;
        end
    end

    // Data and count channel follow the strobes in the same cycle
    always_ff @(posedge clock) begin
        ctrl_o.internal_data <= data_q;
        ctrl_o.count_select  <= channel_t'(address_q[1:0]);
    end

endmodule

/* design/dma_priority_encoder.sv */
// Command, mask and request registers with request latching, edge lock and priority resolution
module dma_priority_encoder (
    input  logic                  clock,
    input  logic                  reset,
    dma_ctrl_if.encoder           ctrl_i,
    input  dma_pkg::channel_t     dma_rotate_i,
    input  dma_pkg::channel_vec_t edge_request_i,
    input  dma_pkg::channel_vec_t dma_request_i,
    input  dma_pkg::channel_vec_t dma_ack_i,
    input  logic                  end_of_process_i,
    output dma_pkg::channel_vec_t encoded_dma_o
);
    import dma_pkg::*;

    logic         controller_disable;
    logic         rotating_priority;
    logic         active_low;
    channel_vec_t mask_reg;
    channel_vec_t request_reg;
    channel_vec_t request_ff;
    channel_vec_t request_lock;
    channel_vec_t live_request;
    channel_vec_t rotated_request;
    channel_vec_t resolved_request;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            controller_disable <= 1'b0;
            rotating_priority  <= 1'b0;
            active_low         <= 1'b0;
        end else if (ctrl_i.master_clear) begin
            controller_disable <= 1'b0;
            rotating_priority  <= 1'b0;
            active_low         <= 1'b0;
        end else if (ctrl_i.write_command) begin
            controller_disable <= ctrl_i.internal_data[cmd_disable_bit];
            rotating_priority  <= ctrl_i.internal_data[cmd_rotate_bit];
            active_low         <= ctrl_i.internal_data[cmd_active_low_bit];
        end
    end

    // All channels come up masked
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mask_reg <= '1;
        end else if (ctrl_i.master_clear) begin
            mask_reg <= '1;
        end else if (ctrl_i.clear_mask) begin
            mask_reg <= '0;
        end else if (ctrl_i.write_all_mask) begin
            mask_reg <= ctrl_i.internal_data[num_channels-1:0];
        end else if (ctrl_i.write_single_mask) begin
            mask_reg[ctrl_i.internal_data[1:0]] <= ctrl_i.internal_data[set_bit];
        end
    end

    // Software request, dropped once its channel reaches terminal count
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            request_reg <= '0;
        end else if (ctrl_i.master_clear) begin
            request_reg <= '0;
        end else if (ctrl_i.write_request) begin
            request_reg[ctrl_i.internal_data[1:0]] <= ctrl_i.internal_data[set_bit];
        end else if (end_of_process_i) begin
            request_reg <= request_reg & ~dma_ack_i;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            request_ff <= '0;
        end else if (ctrl_i.master_clear) begin
            request_ff <= '0;
        end else begin
            request_ff <= active_low ? ~dma_request_i : dma_request_i;
        end
    end

    // Edge-mode channel stays locked from its acknowledge until the request falls
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            request_lock <= '0;
        end else if (ctrl_i.master_clear) begin
            request_lock <= '0;
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                if (!edge_request_i[i]) begin
                    request_lock[i] <= 1'b0;
                end else if (dma_ack_i[i]) begin
                    request_lock[i] <= 1'b1;
                end else if (!request_ff[i]) begin
                    request_lock[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        live_request = (request_ff & ~request_lock & ~mask_reg) | request_reg;
        if (rotating_priority) begin
            rotated_request = rotate_right(live_request, dma_rotate_i);
        end else begin
            rotated_request = live_request;
        end
        resolved_request = resolve_priority(rotated_request);
        if (controller_disable) begin
            encoded_dma_o = '0;
        end else if (rotating_priority) begin
            encoded_dma_o = rotate_left(resolved_request, dma_rotate_i);
        end else begin
            encoded_dma_o = resolved_request;
        end
    end

endmodule

/* design/dma_service_sequencer.sv */
// Grant FSM with transfer counts, four-phase agent handshake, end of process and rotation pointer
module dma_service_sequencer (
    input  logic                  clock,
    input  logic                  reset,
    dma_ctrl_if.sequencer         ctrl_i,
    input  dma_pkg::channel_vec_t encoded_dma_i,
    input  logic                  xfer_ack_i,
    output dma_pkg::channel_vec_t edge_request_o,
    output dma_pkg::channel_vec_t dma_ack_o,
    output dma_pkg::channel_t     dma_rotate_o,
    output logic                  end_of_process_o,
    output logic                  xfer_req_o
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_request,
        state_release,
        state_finish
    } state_t;

    state_t       state;
    channel_vec_t edge_mode;
    logic [7:0]   base_count [num_channels];
    logic [7:0]   current_count [num_channels];
    channel_t     served_channel;
    logic         handshake_done;
    logic         terminal_count;

    assign edge_request_o = edge_mode;

    always_comb begin
        served_channel = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (dma_ack_o[i]) begin
                served_channel = channel_t'(i);
            end
        end
    end

    assign handshake_done = (state == state_release) && !xfer_ack_i;
    assign terminal_count = (current_count[served_channel] == 8'd0);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            edge_mode <= '0;
        end else if (ctrl_i.master_clear) begin
            edge_mode <= '0;
        end else if (ctrl_i.write_mode) begin
            edge_mode[ctrl_i.internal_data[1:0]] <= ctrl_i.internal_data[mode_edge_bit];
        end
    end

    // Master clear leaves the counts alone
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_channels; i++) begin
                base_count[i]    <= 8'd0;
                current_count[i] <= 8'd0;
            end
        end else if (ctrl_i.write_count) begin
            base_count[ctrl_i.count_select]    <= ctrl_i.internal_data;
            current_count[ctrl_i.count_select] <= ctrl_i.internal_data;
        end else if (handshake_done) begin
            if (terminal_count) begin
                current_count[served_channel] <= base_count[served_channel];
            end else begin
                current_count[served_channel] <= current_count[served_channel] - 8'd1;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state            <= state_idle;
            dma_ack_o        <= '0;
            xfer_req_o       <= 1'b0;
            end_of_process_o <= 1'b0;
            dma_rotate_o     <= '0;
        end else if (ctrl_i.master_clear) begin
            state            <= state_idle;
            dma_ack_o        <= '0;
            xfer_req_o       <= 1'b0;
            end_of_process_o <= 1'b0;
            dma_rotate_o     <= '0;
        end else begin
            case (state)
                state_idle: begin
                    // Agent must have released ack before a new request
                    if ((encoded_dma_i != '0) && !xfer_ack_i) begin
                        dma_ack_o  <= encoded_dma_i;
                        xfer_req_o <= 1'b1;
                        state      <= state_request;
                    end
                end
                state_request: begin
                    if (xfer_ack_i) begin
                        xfer_req_o <= 1'b0;
                        state      <= state_release;
                    end
                end
                state_release: begin
                    if (!xfer_ack_i) begin
                        end_of_process_o <= terminal_count;
                        state            <= state_finish;
                    end
                end
                state_finish: begin
                    end_of_process_o <= 1'b0;
                    dma_ack_o        <= '0;
                    dma_rotate_o     <= served_channel + channel_t'(1);
                    state            <= state_idle;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

endmodule

/* design/dma_arbiter_top.sv */
// Top level of the four-channel DMA arbiter, wiring decoder, encoder and sequencer to the pins
module dma_arbiter_top (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               cpu_write_i,
    input  logic [3:0]                         cpu_address_i,
    input  logic [7:0]                         cpu_data_i,
    input  logic [dma_pkg::num_channels-1:0]   dreq_i,
    input  logic                               xfer_ack_i,
    output logic [dma_pkg::num_channels-1:0]   dack_o,
    output logic                               xfer_req_o,
    output logic                               eop_o
);
    import dma_pkg::*;

    channel_vec_t encoded_dma;
    channel_vec_t edge_request;
    channel_vec_t dma_ack;
    channel_t     dma_rotate;
    logic         end_of_process;

    dma_ctrl_if ctrl_bus ();

    dma_register_decoder i_dma_register_decoder (
        .clock         (clock),
        .reset         (reset),
        .cpu_write_i   (cpu_write_i),
        .cpu_address_i (cpu_address_i),
        .cpu_data_i    (cpu_data_i),
        .ctrl_o        (ctrl_bus.decoder)
    );

    dma_priority_encoder i_dma_priority_encoder (
        .clock            (clock),
        .reset            (reset),
        .ctrl_i           (ctrl_bus.encoder),
        .dma_rotate_i     (dma_rotate),
        .edge_request_i   (edge_request),
        .dma_request_i    (dreq_i),
        .dma_ack_i        (dma_ack),
        .end_of_process_i (end_of_process),
        .encoded_dma_o    (encoded_dma)
    );

    dma_service_sequencer i_dma_service_sequencer (
        .clock            (clock),
        .reset            (reset),
        .ctrl_i           (ctrl_bus.sequencer),
        .encoded_dma_i    (encoded_dma),
        .xfer_ack_i       (xfer_ack_i),
        .edge_request_o   (edge_request),
        .dma_ack_o        (dma_ack),
        .dma_rotate_o     (dma_rotate),
        .end_of_process_o (end_of_process),
        .xfer_req_o       (xfer_req_o)
    );

    assign dack_o = dma_ack;
    assign eop_o  = end_of_process;

endmodule

/* sim/dma_clock_gen.sv */
// Testbench clock and reset source, reset held high for the first ten clock cycles
module dma_clock_gen #(
    parameter int period = 40
) (
    output logic clock_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock_o = 1'b0;
        forever #(period / 2) clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

/* sim/dma_arbiter_tb.sv */
// Testbench for the DMA arbiter with transfer-agent model, reference arbitration and watchdog
module dma_arbiter_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dma_pkg::*;

    localparam int clock_period = 40;
    localparam int num_tests    = 5;

    logic         clock;
    logic         reset;
    logic         cpu_write_i;
    logic [3:0]   cpu_address_i;
    logic [7:0]   cpu_data_i;
    channel_vec_t dreq_i;
    logic         xfer_ack_i;
    channel_vec_t dack_o;
    logic         xfer_req_o;
    logic         eop_o;

    int           seed = 32'heea83205;
    string        test_name = "reset";
    bit           check_on = 1'b1;
    int           grant_count = 0;
    channel_vec_t dack_prev = '0;
    bit           eop_seen;

    // Mirror of the arbiter registers, kept from the register writes
    bit           cmd_disable = 1'b0;
    bit           cmd_rotate = 1'b0;
    bit           cmd_active_low = 1'b0;
    channel_vec_t mask_m = '1;
    channel_vec_t sw_request_m = '0;
    channel_vec_t edge_m = '0;
    channel_vec_t lock_m = '0;
    channel_t     pointer_m = '0;
    logic [7:0]   base_m [num_channels] = '{default: 8'd0};
    logic [7:0]   count_m [num_channels] = '{default: 8'd0};

    dma_clock_gen #(.period(clock_period)) i_dma_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    dma_arbiter_top i_dma_arbiter_top (
        .clock         (clock),
        .reset         (reset),
        .cpu_write_i   (cpu_write_i),
        .cpu_address_i (cpu_address_i),
        .cpu_data_i    (cpu_data_i),
        .dreq_i        (dreq_i),
        .xfer_ack_i    (xfer_ack_i),
        .dack_o        (dack_o),
        .xfer_req_o    (xfer_req_o),
        .eop_o         (eop_o)
    );

    function automatic channel_vec_t expected_grant(bit disable_bit, bit rotate_bit,
            bit active_low_bit, channel_vec_t mask, channel_vec_t sw_request,
            channel_vec_t dreq, channel_vec_t lock, channel_t pointer);
        channel_vec_t live;
        channel_t     channel;
        live = ((active_low_bit ? ~dreq : dreq) & ~lock & ~mask) | sw_request;
        if (disable_bit) begin
            return '0;
        end
        // Search upward from the pointer when rotating, from channel 0 otherwise
        for (int k = 0; k < num_channels; k++) begin
            channel = rotate_bit ? pointer + channel_t'(k) : channel_t'(k);
            if (live[channel]) begin
                return channel_vec_t'(1) << channel;
            end
        end
        return '0;
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_grant(string name, channel_vec_t expected, channel_vec_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s dack expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_eop(string name, bit expected, bit actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s eop expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic write_reg(logic [3:0] address, logic [7:0] data);
        @(negedge clock);
        cpu_write_i   = 1'b1;
        cpu_address_i = address;
        cpu_data_i    = data;
        @(negedge clock);
        cpu_write_i = 1'b0;
    endtask

    task automatic wait_cycles(int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    task automatic wait_grants(int grants);
        int target;
        target = grant_count + grants;
        while (grant_count < target) @(negedge clock);
    endtask

    // Masks every channel and lets a running grant finish
    task automatic quiesce();
        check_on = 1'b0;
        mask_m   = '1;
        write_reg(addr_all_mask, 8'h0f);
        wait_cycles(3);
        while (dack_o != '0) @(negedge clock);
        wait_cycles(2);
        check_on = 1'b1;
    endtask

    task automatic run_pattern(channel_vec_t pattern, channel_vec_t mask_pattern, int grants);
        quiesce();
        dreq_i = pattern;
        wait_cycles(3);
        mask_m = mask_pattern;
        write_reg(addr_all_mask, {4'h0, mask_pattern});
        if (expected_grant(cmd_disable, cmd_rotate, cmd_active_low, mask_m, sw_request_m,
                dreq_i, lock_m, pointer_m) != '0) begin
            wait_grants(grants);
        end else begin
            wait_cycles(20);
        end
    endtask

    task automatic retire_grant(channel_vec_t served);
        channel_t channel;
        bit       terminal;
        channel = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (served[i]) begin
                channel = channel_t'(i);
            end
        end
        terminal = (count_m[channel] == 8'd0);
        if (check_on) begin
            check_eop(test_name, terminal, eop_seen);
        end
        count_m[channel] = terminal ? base_m[channel] : count_m[channel] - 8'd1;
        if (terminal) begin
            sw_request_m[channel] = 1'b0;
        end
        pointer_m = channel + channel_t'(1);
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            if (dack_o != '0 && dack_prev == '0) begin
                if (check_on) begin
                    check_grant(test_name, expected_grant(cmd_disable, cmd_rotate,
                        cmd_active_low, mask_m, sw_request_m, dreq_i, lock_m, pointer_m), dack_o);
                end
                grant_count++;
                eop_seen = 1'b0;
                lock_m   = lock_m | (dack_o & edge_m);
            end
            if (dack_o != '0 && eop_o) begin
                eop_seen = 1'b1;
            end
            if (dack_o == '0 && dack_prev != '0) begin
                retire_grant(dack_prev);
            end
        end
        dack_prev = dack_o;
    end

    // Agent acknowledge only moves on falling edges, so it is stable here
    always @(posedge xfer_req_o) begin
        if (xfer_ack_i) begin
            abort_run("Transfer request rose while the agent still held its acknowledge");
        end
    end

    // Transfer agent answers each request after a random delay
    initial begin : transfer_agent
        xfer_ack_i = 1'b0;
        forever begin
            @(negedge clock);
            if (xfer_req_o && !xfer_ack_i) begin
                repeat ($random(seed) & 3) @(negedge clock);
                xfer_ack_i = 1'b1;
                while (xfer_req_o) @(negedge clock);
                repeat ($random(seed) & 3) @(negedge clock);
                xfer_ack_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #((num_tests * 400 + 10) * clock_period);
        abort_run("Timeout, the tests did not complete within the allowed time");
    end

    initial begin : stimulus
        int start;
        cpu_write_i   = 1'b0;
        cpu_address_i = '0;
        cpu_data_i    = '0;
        dreq_i        = '0;
        @(negedge reset);
        wait_cycles(2);

        test_name = "fixed_priority";
        for (int n = 0; n < 6; n++) begin
            run_pattern(channel_vec_t'($random(seed)),
                (n < 3) ? channel_vec_t'(0) : channel_vec_t'($random(seed)), 2);
        end

        test_name = "rotating_priority";
        quiesce();
        cmd_rotate = 1'b1;
        write_reg(addr_command, 8'h10);
        run_pattern(4'b1111, '0, 8);
        for (int n = 0; n < 3; n++) begin
            run_pattern(channel_vec_t'($random(seed)), '0, 4);
        end

        test_name = "terminal_count";
        quiesce();
        dreq_i    = '0;
        base_m[2] = 8'd2;
        count_m[2] = 8'd2;
        write_reg(addr_count_2, 8'd2);
        start = grant_count;
        sw_request_m[2] = 1'b1;
        write_reg(addr_request, 8'h06);
        wait_grants(3);
        wait_cycles(30);
        if (grant_count != start + 3) begin
            abort_run("Software request did not stop after terminal count");
        end

        test_name = "polarity";
        quiesce();
        cmd_rotate     = 1'b0;
        cmd_active_low = 1'b1;
        write_reg(addr_command, 8'h40);
        for (int n = 0; n < 3; n++) begin
            run_pattern(channel_vec_t'($random(seed)), '0, 2);
        end
        test_name = "disable";
        quiesce();
        cmd_disable = 1'b1;
        write_reg(addr_command, 8'h44);
        start = grant_count;
        run_pattern(4'b0000, '0, 0);
        if (grant_count != start) begin
            abort_run("A channel was acknowledged while the controller was disabled");
        end

        test_name = "edge_mode";
        quiesce();
        cmd_disable    = 1'b0;
        cmd_active_low = 1'b0;
        write_reg(addr_command, 8'h00);
        edge_m[1] = 1'b1;
        write_reg(addr_mode, 8'h81);
        start = grant_count;
        run_pattern(4'b0010, '0, 1);
        wait_cycles(30);
        if (grant_count != start + 1) begin
            abort_run("Edge-mode channel was served again while its request stayed high");
        end
        dreq_i    = '0;
        lock_m[1] = 1'b0;
        wait_cycles(4);
        dreq_i = 4'b0010;
        wait_grants(1);

        test_name = "master_clear";
        quiesce();
        cmd_rotate = 1'b1;
        write_reg(addr_command, 8'h10);
        // Masks open and no request pending before master clear
        dreq_i = '0;
        mask_m = '0;
        write_reg(addr_clear_mask, 8'h00);
        wait_cycles(2);
        // Master clear brings back the reset state, counts excepted
        cmd_rotate   = 1'b0;
        mask_m       = '1;
        edge_m       = '0;
        lock_m       = '0;
        sw_request_m = '0;
        pointer_m    = '0;
        write_reg(addr_master_clear, 8'h00);
        wait_cycles(2);
        dreq_i = 4'b1010;
        start  = grant_count;
        wait_cycles(40);
        if (grant_count != start) begin
            abort_run("A channel was acknowledged after master clear with all channels masked");
        end
        mask_m = '0;
        write_reg(addr_clear_mask, 8'h00);
        wait_grants(3);

        $display("Everything OK");
        $finish;
    end

endmodule

/* compile.f */
design/dma_pkg.sv
design/dma_ctrl_if.sv
design/dma_register_decoder.sv
design/dma_priority_encoder.sv
design/dma_service_sequencer.sv
design/dma_arbiter_top.sv
sim/dma_clock_gen.sv
sim/dma_arbiter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DMA arbiter testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module dma_arbiter_tb \
    -f compile.f -o dma_arbiter_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/dma_arbiter_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
